//--- design/kyber_config.svh
`ifndef KYBER_CONFIG_SVH
`define KYBER_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// modulus and reduction factors
//////////////////////////////////////////////////////////////////////

// kyber prime
`define KYBER_Q          3329
// q^-1 mod 2^16, montgomery step
`define KYBER_QINV       62209
// round(2^26 / q), barrett estimate
`define KYBER_BARRETT_V  20159

//////////////////////////////////////////////////////////////////////
// pipeline depths in cycles
//////////////////////////////////////////////////////////////////////

`define MONT_LATENCY     4
`define BARRETT_LATENCY  3
// operand reg + product reg + montgomery + combine + barrett
`define BFLY_LATENCY     10

`endif

//--- design/kyber_pkg.sv
package kyber_pkg;

  //////////////////////////////////////////////////////////////////////
  // scalar types
  //////////////////////////////////////////////////////////////////////

  // one coefficient, signed, wide enough for sums of two reduced values
  typedef logic signed [15:0] coeff_t;

  // full product of two coefficients
  typedef logic signed [31:0] prod_t;

  // butterfly flavour
  typedef enum logic {
    mode_ct = 1'b0,  // forward ntt, cooley-tukey
    mode_gs = 1'b1   // inverse ntt, gentleman-sande
  } bfly_mode_e;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  // one butterfly request, 49 bits
  typedef struct packed {
    coeff_t     a;
    coeff_t     b;
    coeff_t     zeta;
    bfly_mode_e mode;
  } bfly_in_t;

  // reduced butterfly result, 32 bits
  typedef struct packed {
    coeff_t a;
    coeff_t b;
  } bfly_out_t;

  // rides alongside the montgomery pipe, 17 bits
  typedef struct packed {
    coeff_t     keep;
    bfly_mode_e mode;
  } side_t;

endpackage

//--- design/shift_delay.sv
`timescale 1ns/1ps

module shift_delay #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  payload_t din,
  output payload_t dout
);

  //////////////////////////////////////////////////////////////////////
  // register chain
  //////////////////////////////////////////////////////////////////////

  // stage 0 nearest the input
  payload_t stage_q [DEPTH];

  // a zero-depth line makes no sense here
  if (DEPTH < 1) begin : g_depth_check
    $error("shift_delay needs DEPTH of at least 1");
  end

  // payload only, timing comes from the pipe next door
  always_ff @(posedge clk) begin
    stage_q[0] <= din;
    for (int i = 1; i < DEPTH; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  // oldest entry
  assign dout = stage_q[DEPTH-1];

endmodule

//--- design/montgomery_reduce.sv
`timescale 1ns/1ps
`include "kyber_config.svh"

module montgomery_reduce (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ce,
  input  kyber_pkg::prod_t  a,
  output kyber_pkg::coeff_t res,
  output logic              done
);

  import kyber_pkg::*;

  localparam prod_t QINV    = prod_t'(`KYBER_QINV);
  localparam prod_t Q       = prod_t'(`KYBER_Q);
  // |a| must stay under q * 2^15 for a result inside (-q, q)
  localparam prod_t A_BOUND = prod_t'(`KYBER_Q * 32768);

  //////////////////////////////////////////////////////////////////////
  // strobe chain
  //////////////////////////////////////////////////////////////////////

  logic [`MONT_LATENCY-1:0] ce_chain;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ce_chain <= '0;
    end else begin
      ce_chain <= {ce_chain[`MONT_LATENCY-2:0], ce};
    end
  end

  // top bit, same cycle as res
  assign done = ce_chain[`MONT_LATENCY-1];

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  prod_t  a_q;
  prod_t  a_dly;
  prod_t  qa_prod;
  coeff_t u_q;
  prod_t  t_q;
  prod_t  diff;

  // only the low half of a * qinv matters
  assign qa_prod = a_q * QINV;

  // low 16 bits cancel exactly
  assign diff = a_dly - t_q;

  always_ff @(posedge clk) begin
    // stage 1, capture
    a_q <= a;
    // stage 2, u = a * qinv mod 2^16, signed
    u_q <= qa_prod[15:0];
    // stage 3, t = u * q
    t_q <= prod_t'(u_q) * Q;
    // stage 4, (a - t) >> 16
    res <= diff[31:16];
  end

  // raw input, two more cycles so it meets t
  shift_delay #(
    .payload_t (prod_t),
    .DEPTH     (`MONT_LATENCY - 2)
  ) u_raw_delay (
    .clk  (clk),
    .din  (a_q),
    .dout (a_dly)
  );

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // input bound for the (-q, q) output range
  a_bound_a: assert property (@(posedge clk) disable iff (!arst_n)
    ce |-> (a < A_BOUND) && (a > -A_BOUND))
    else $error("montgomery input out of range: %0d", a);

endmodule

//--- design/barrett_reduce.sv
`timescale 1ns/1ps
`include "kyber_config.svh"

module barrett_reduce (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              valid_in,
  input  kyber_pkg::coeff_t x,
  output logic              valid_out,
  output kyber_pkg::coeff_t y
);

  import kyber_pkg::*;

  localparam prod_t V     = prod_t'(`KYBER_BARRETT_V);
  localparam prod_t Q     = prod_t'(`KYBER_Q);
  // half of 2^26, rounds the quotient
  localparam prod_t ROUND = prod_t'(1 << 25);

  //////////////////////////////////////////////////////////////////////
  // valid chain
  //////////////////////////////////////////////////////////////////////

  logic [`BARRETT_LATENCY-1:0] vld_chain;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_chain <= '0;
    end else begin
      vld_chain <= {vld_chain[`BARRETT_LATENCY-2:0], valid_in};
    end
  end

  assign valid_out = vld_chain[`BARRETT_LATENCY-1];

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  coeff_t x_q;
  coeff_t x_dly;
  coeff_t quot_q;
  prod_t  xv;
  prod_t  rem;

  // quotient estimate before the shift
  assign xv = prod_t'(x_q) * V + ROUND;
  // centred remainder, roughly within +-q/2
  assign rem = prod_t'(x_dly) - prod_t'(quot_q) * Q;

  always_ff @(posedge clk) begin
    x_q    <= x;
    x_dly  <= x_q;
    quot_q <= coeff_t'(xv >>> 26);
    // fold negatives up by one q
    y      <= (rem < 0) ? coeff_t'(rem + Q) : coeff_t'(rem);
  end

  // output range seen by the butterfly
  y_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    valid_out |-> (y >= 0) && (y <= Q))
    else $error("barrett result out of range: %0d", y);

endmodule

//--- design/kyber_butterfly.sv
`timescale 1ns/1ps
`include "kyber_config.svh"

module kyber_butterfly (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  kyber_pkg::bfly_in_t  in,
  output logic                 out_valid,
  output kyber_pkg::bfly_out_t out
);

  import kyber_pkg::*;

  localparam coeff_t Q = coeff_t'(`KYBER_Q);

  //////////////////////////////////////////////////////////////////////
  // stage 1 operand forming
  //////////////////////////////////////////////////////////////////////

  logic       s1_valid;
  coeff_t     s1_keep;
  coeff_t     s1_mult;
  coeff_t     s1_zeta;
  bfly_mode_e s1_mode;

  coeff_t     keep_d;
  coeff_t     mult_d;

  // ct keeps a and multiplies b
  // gs keeps a+b and multiplies b-a
  always_comb begin
    if (in.mode == mode_gs) begin
      keep_d = in.a + in.b;
      mult_d = in.b - in.a;
    end else begin
      keep_d = in.a;
      mult_d = in.b;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // operand registers
  always_ff @(posedge clk) begin
    s1_keep <= keep_d;
    s1_mult <= mult_d;
    s1_zeta <= in.zeta;
    s1_mode <= in.mode;
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2 twiddle product
  //////////////////////////////////////////////////////////////////////

  logic  s2_valid;
  prod_t s2_prod;
  side_t s2_side;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_prod      <= prod_t'(s1_zeta) * prod_t'(s1_mult);
    // side data enters the delay line with the product
    s2_side.keep <= s1_keep;
    s2_side.mode <= s1_mode;
  end

  //////////////////////////////////////////////////////////////////////
  // montgomery reduction and side delay
  //////////////////////////////////////////////////////////////////////

  coeff_t mont_t;
  logic   mont_done;
  side_t  side_dly;

  montgomery_reduce u_montgomery_reduce (
    .clk    (clk),
    .arst_n (arst_n),
    .ce     (s2_valid),
    .a      (s2_prod),
    .res    (mont_t),
    .done   (mont_done)
  );

  // keep and mode delayed to match the montgomery depth
  shift_delay #(
    .payload_t (side_t),
    .DEPTH     (`MONT_LATENCY)
  ) u_side_delay (
    .clk  (clk),
    .din  (s2_side),
    .dout (side_dly)
  );

  //////////////////////////////////////////////////////////////////////
  // combine
  //////////////////////////////////////////////////////////////////////

  logic   c_valid;
  coeff_t c_a;
  coeff_t c_b;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      c_valid <= 1'b0;
    end else begin
      c_valid <= mont_done;
    end
  end

  // ct forms keep +- t
  // gs passes the sum through and t becomes the new b
  always_ff @(posedge clk) begin
    if (mont_done) begin
      if (side_dly.mode == mode_gs) begin
        c_a <= side_dly.keep;
        c_b <= mont_t;
      end else begin
        c_a <= side_dly.keep + mont_t;
        c_b <= side_dly.keep - mont_t;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // final reduction with one barrett per lane
  //////////////////////////////////////////////////////////////////////

  coeff_t res_a;
  coeff_t res_b;

  // a lane provides the output strobe
  barrett_reduce u_barrett_a (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (c_valid),
    .x         (c_a),
    .valid_out (out_valid),
    .y         (res_a)
  );

  // b lane runs in lockstep and its strobe goes unused
  barrett_reduce u_barrett_b (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (c_valid),
    .x         (c_b),
    .valid_out (),
    .y         (res_b)
  );

  assign out = '{a: res_a, b: res_b};

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // coefficients and twiddle already reduced to (-q, q)
  in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> (in.a > -Q) && (in.a < Q)
              && (in.b > -Q) && (in.b < Q)
              && (in.zeta > -Q) && (in.zeta < Q))
    else $error("butterfly input out of range");

  // side data and montgomery result land together
  // done trails the registered strobe by montgomery depth plus stage 2
  side_align_a: assert property (@(posedge clk) disable iff (!arst_n)
    mont_done == $past(s1_valid, `MONT_LATENCY + 1))
    else $error("montgomery done misaligned with side data");

endmodule

//--- testbench/tb_kyber_butterfly.sv
`timescale 1ns/1ps
`include "kyber_config.svh"

module tb_kyber_butterfly;

  import kyber_pkg::*;

  localparam int Q          = `KYBER_Q;
  localparam int LAT        = `BFLY_LATENCY;
  localparam int RST_CYCLES = 4;
  localparam int NUM_ROWS   = 14;
  localparam int N_B2B      = 200;
  localparam int N_SPARSE   = 100;
  localparam int MAX_GAP    = 4;
  // input slots, sparse gaps, one drain per test and a margin
  localparam int CYCLE_LIMIT = RST_CYCLES + NUM_ROWS + N_B2B + N_SPARSE * (1 + MAX_GAP)
                             + 6 * (LAT + 2) + 50;

  // one directed case with its precomputed result
  typedef struct packed {
    bfly_mode_e mode;
    coeff_t     a;
    coeff_t     b;
    coeff_t     zeta;
    bfly_out_t  want;
  } vec_t;

  // result still in flight
  typedef struct packed {
    bfly_out_t val;
    int        due;
  } pend_t;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  bfly_in_t  bfly_in;
  logic      out_valid;
  bfly_out_t bfly_out;

  int          cycle = 0;
  int          err_count = 0;
  int          range_errs = 0;
  int          results_seen = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [31:0] rng;
  pend_t       pend_q[$];
  vec_t        vecs [NUM_ROWS];

  kyber_butterfly u_kyber_butterfly (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in        (bfly_in),
    .out_valid (out_valid),
    .out       (bfly_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // cycle count and watchdog
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d results never arrived", cycle, pend_q.size());
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // (p - u*q) / 2^16 with u the signed low half of p*qinv
  function automatic int mont_model(input int p);
    int u;
    u = int'(shortint'(p * `KYBER_QINV));
    return (p - u * Q) >>> 16;
  endfunction

  // rounded quotient then a fold into [0, q]
  function automatic int barrett_model(input int x);
    int quot;
    int rem;
    quot = (x * `KYBER_BARRETT_V + (1 << 25)) >>> 26;
    rem  = x - quot * Q;
    if (rem < 0) begin
      rem = rem + Q;
    end
    return rem;
  endfunction

  function automatic bfly_out_t bfly_model(input bfly_mode_e m, input int a, input int b,
                                           input int z);
    int        t;
    bfly_out_t r;
    if (m == mode_ct) begin
      t   = mont_model(z * b);
      r.a = coeff_t'(barrett_model(a + t));
      r.b = coeff_t'(barrett_model(a - t));
    end else begin
      t   = mont_model(z * (b - a));
      r.a = coeff_t'(barrett_model(a + b));
      r.b = coeff_t'(barrett_model(t));
    end
    return r;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // uniform in (-q, q)
  task automatic rand_coeff(output int v);
    rng = xorshift32(rng);
    v   = int'(rng % 32'(2 * Q - 1)) - (Q - 1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed cases
  //////////////////////////////////////////////////////////////////////

  function automatic vec_t make_row(input bfly_mode_e m, input int a, input int b,
                                    input int z, input int ea, input int eb);
    vec_t r;
    r.mode   = m;
    r.a      = coeff_t'(a);
    r.b      = coeff_t'(b);
    r.zeta   = coeff_t'(z);
    r.want.a = coeff_t'(ea);
    r.want.b = coeff_t'(eb);
    return r;
  endfunction

  // mont(k) = 169k for small k and mont(q-1) = -169
  task automatic fill_table();
    vecs[0]  = make_row(mode_ct, 0, 0, 0, 0, 0);
    vecs[1]  = make_row(mode_ct, 5, 1, 1, 174, 3165);
    vecs[2]  = make_row(mode_ct, 0, 1, -1, 3160, 169);
    vecs[3]  = make_row(mode_ct, 3328, 3328, 1, 3159, 168);
    vecs[4]  = make_row(mode_ct, -3328, -3328, -1, 3161, 170);
    vecs[5]  = make_row(mode_ct, -3328, 0, 5, 1, 1);
    vecs[6]  = make_row(mode_ct, 100, 9, 1, 1621, 1908);
    vecs[7]  = make_row(mode_gs, 0, 0, 0, 0, 0);
    vecs[8]  = make_row(mode_gs, 7, 7, 3328, 14, 0);
    vecs[9]  = make_row(mode_gs, 0, 1, 1, 1, 169);
    vecs[10] = make_row(mode_gs, 1, 0, 1, 1, 3160);
    vecs[11] = make_row(mode_gs, 3328, 3328, 1234, 3327, 0);
    vecs[12] = make_row(mode_gs, -3328, -3328, 1, 2, 0);
    vecs[13] = make_row(mode_gs, -3328, 3328, -1, 0, 338);
  endtask

  //////////////////////////////////////////////////////////////////////
  // driving
  //////////////////////////////////////////////////////////////////////

  // called 1 ns after a rising edge
  task automatic apply(input bfly_mode_e m, input int a, input int b, input int z,
                       input bfly_out_t want);
    pend_t p;
    bfly_in.mode = m;
    bfly_in.a    = coeff_t'(a);
    bfly_in.b    = coeff_t'(b);
    bfly_in.zeta = coeff_t'(z);
    in_valid     = 1'b1;
    p.val        = want;
    p.due        = cycle + LAT;
    pend_q.push_back(p);
  endtask

  task automatic next_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic go_idle();
    in_valid = 1'b0;
    bfly_in  = '0;
  endtask

  // wait until the pipeline is empty
  task automatic drain();
    while (pend_q.size() > 0) begin
      @(posedge clk);
    end
    next_slot();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = err_count - errs_before;
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errs);
    end
  endtask

  task automatic run_rows(input bfly_mode_e m, input string name);
    int        e0;
    bfly_out_t model;
    e0 = err_count;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (vecs[i].mode == m) begin
        model = bfly_model(m, vecs[i].a, vecs[i].b, vecs[i].zeta);
        // model against the hand values
        if (model != vecs[i].want) begin
          $display("model and table disagree on row %0d", i);
          err_count++;
        end
        apply(m, vecs[i].a, vecs[i].b, vecs[i].zeta, vecs[i].want);
        next_slot();
      end
    end
    go_idle();
    drain();
    finish_test(name, e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor sampled at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    pend_t p;
    int    ga;
    int    gb;
    ga = int'(bfly_out.a);
    gb = int'(bfly_out.b);
    if (out_valid) begin
      if (pend_q.size() == 0) begin
        $display("out_valid high at cycle %0d with no butterfly in flight", cycle);
        err_count++;
      end else begin
        p = pend_q.pop_front();
        results_seen++;
        if (p.due != cycle) begin
          $display("result arrived at cycle %0d but was due at %0d", cycle, p.due);
          err_count++;
        end
        if (bfly_out.a !== p.val.a) begin
          $display("FAILED out.a got 0x%04h expected 0x%04h", bfly_out.a, p.val.a);
          err_count++;
        end
        if (bfly_out.b !== p.val.b) begin
          $display("FAILED out.b got 0x%04h expected 0x%04h", bfly_out.b, p.val.b);
          err_count++;
        end
        // both lanes in [0, q]
        if (ga < 0 || ga > Q || gb < 0 || gb > Q) begin
          $display("result outside 0 to q at cycle %0d", cycle);
          range_errs++;
        end
      end
    end else if (pend_q.size() > 0 && pend_q[0].due <= cycle) begin
      p = pend_q.pop_front();
      $display("no out_valid for the result due at cycle %0d", p.due);
      err_count++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int         e0;
    int         n0;
    int         a;
    int         b;
    int         z;
    int         gap;
    bfly_mode_e m;
    rng      = 32'hfc201e3b;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    bfly_in  = '0;
    fill_table();

    // reset then idle long enough for a stray result
    e0 = err_count;
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
      #1;
      if (out_valid !== 1'b0) begin
        $display("out_valid not low in reset cycle %0d", i);
        err_count++;
      end
    end
    arst_n = 1'b1;
    repeat (LAT + 2) next_slot();
    finish_test("reset", e0);

    run_rows(mode_ct, "forward");
    run_rows(mode_gs, "inverse");

    // one request per cycle with mixed modes
    e0 = err_count;
    n0 = results_seen;
    for (int i = 0; i < N_B2B; i++) begin
      rand_coeff(a);
      rand_coeff(b);
      rand_coeff(z);
      rng = xorshift32(rng);
      m   = bfly_mode_e'(rng[7]);
      apply(m, a, b, z, bfly_model(m, a, b, z));
      next_slot();
    end
    go_idle();
    drain();
    if (results_seen - n0 != N_B2B) begin
      $display("stream gave %0d results for %0d inputs", results_seen - n0, N_B2B);
      err_count++;
    end
    finish_test("back_to_back", e0);

    // single requests with 1..MAX_GAP idle cycles after each
    e0 = err_count;
    n0 = results_seen;
    for (int i = 0; i < N_SPARSE; i++) begin
      rand_coeff(a);
      rand_coeff(b);
      rand_coeff(z);
      rng = xorshift32(rng);
      m   = bfly_mode_e'(rng[3]);
      gap = 1 + int'(rng[31:16] % 16'(MAX_GAP));
      apply(m, a, b, z, bfly_model(m, a, b, z));
      next_slot();
      go_idle();
      repeat (gap) next_slot();
    end
    drain();
    if (results_seen - n0 != N_SPARSE) begin
      $display("sparse run gave %0d results for %0d inputs", results_seen - n0, N_SPARSE);
      err_count++;
    end
    finish_test("sparse", e0);

    // every result seen so far
    e0 = err_count;
    if (range_errs != 0 || results_seen != NUM_ROWS + N_B2B + N_SPARSE) begin
      $display("%0d results out of range, %0d results seen", range_errs, results_seen);
      err_count++;
    end
    finish_test("range", e0);

    $display("summary: %0d passing, %0d failing", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+design
design/kyber_pkg.sv
design/shift_delay.sv
design/montgomery_reduce.sv
design/barrett_reduce.sv
design/kyber_butterfly.sv
testbench/tb_kyber_butterfly.sv

//--- run_sim.sh
#!/bin/sh
# build and run the butterfly testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_kyber_butterfly -f flist.f -o tb_kyber_butterfly \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/tb_kyber_butterfly)"
echo "$sim_out"
echo "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1
